/* include/edge_fetch_settings.svh */
////////////////////
// sizes shared by the edge fetch unit
// cacheline and element sizes must be powers of two
// queue depth must be at least one cacheline of edges
////////////////////

`ifndef EDGE_FETCH_SETTINGS_SVH
`define EDGE_FETCH_SETTINGS_SVH

// memory line geometry
`define EF_CACHELINE_BYTES 64
`define EF_EDGE_BYTES      4
`define EF_EDGES_PER_LINE  16

// byte address width on the memory side
`define EF_ADDR_BITS       32

// edge index, degree and sequence width
`define EF_COUNT_BITS      16

// edge queue entries
`define EF_QUEUE_DEPTH     32

`endif

/* hdl/mem_pkg.sv */
////////////////////
// memory side types for the edge fetch unit
// reads are always one full aligned cacheline
////////////////////

`include "edge_fetch_settings.svh"

package mem_pkg;

	// byte address
	typedef logic [`EF_ADDR_BITS-1:0] addr_t;

	// one line of read data, element 0 in the low bits
	typedef logic [`EF_CACHELINE_BYTES*8-1:0] cacheline_t;

	// element position inside a line
	typedef logic [$clog2(`EF_EDGES_PER_LINE)-1:0] line_offset_t;

	// which edge array a command or response belongs to
	typedef enum logic [1:0] {
		ARRAY_SRC    = 2'd0,
		ARRAY_DEST   = 2'd1,
		ARRAY_WEIGHT = 2'd2
	} array_sel_t;

endpackage

/* hdl/edge_pkg.sv */
////////////////////
// graph side types for the edge fetch unit
// vertex ids and weights share the element width
////////////////////

`include "edge_fetch_settings.svh"

package edge_pkg;

	// one array element, vertex id or weight
	typedef logic [`EF_EDGE_BYTES*8-1:0] edge_word_t;

	// edge count, edge index or per-vertex sequence number
	typedef logic [`EF_COUNT_BITS-1:0] edge_count_t;

	// vertex id as given with a job
	typedef logic [31:0] vertex_id_t;

endpackage

/* hdl/edge_cmd_seq.sv */
////////////////////
// read command sequencer, one vertex job at a time
// base addresses must stay stable while vertex_ready is low
// a new chunk waits for the previous one to drain and a line of queue room
////////////////////

`timescale 1ns/1ps
`include "edge_fetch_settings.svh"

module edge_cmd_seq (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   vertex_valid,
	input  edge_pkg::edge_count_t  vertex_edge_idx,
	input  edge_pkg::edge_count_t  vertex_degree,
	input  mem_pkg::addr_t         src_base,
	input  mem_pkg::addr_t         dest_base,
	input  mem_pkg::addr_t         weight_base,
	input  logic                   chunk_busy,
	input  logic                   queue_room,
	output logic                   vertex_ready,
	output logic                   mem_cmd_valid,
	output mem_pkg::addr_t         mem_cmd_addr,
	output mem_pkg::array_sel_t    mem_cmd_array,
	output logic                   chunk_start,
	output mem_pkg::line_offset_t  chunk_offset,
	output edge_pkg::edge_count_t  chunk_count
);

	localparam int LINE_BITS = $clog2(`EF_CACHELINE_BYTES);
	localparam int EDGE_BITS = $clog2(`EF_EDGE_BYTES);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT,
		ST_SIZE,
		ST_SRC,
		ST_DEST,
		ST_WEIGHT
	} seq_state_t;

	seq_state_t state;
	seq_state_t next_state;

	// byte offset of the next edge and edges still to fetch
	mem_pkg::addr_t        next_off;
	edge_pkg::edge_count_t remaining;

	// current chunk
	mem_pkg::addr_t        aligned;

	// chunk arithmetic from next_off and remaining
	mem_pkg::addr_t        calc_aligned;
	mem_pkg::line_offset_t calc_start;
	edge_pkg::edge_count_t calc_left;
	edge_pkg::edge_count_t calc_count;

////////////////////
// chunk sizing
////////////////////

	always_comb begin
		calc_aligned = next_off & ~mem_pkg::addr_t'(`EF_CACHELINE_BYTES - 1);
		calc_start   = next_off[LINE_BITS-1:EDGE_BITS];
		// elements from the start position to the line boundary
		calc_left    = edge_pkg::edge_count_t'(`EF_EDGES_PER_LINE)
			- edge_pkg::edge_count_t'(calc_start);
		if (remaining < calc_left) begin
			calc_count = remaining;
		end else begin
			calc_count = calc_left;
		end
	end

////////////////////
// state machine
////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE: begin
				if (vertex_valid) begin
					next_state = ST_WAIT;
				end
			end
			ST_WAIT: begin
				if (remaining == '0) begin
					next_state = ST_IDLE;
				end else if (!chunk_busy && queue_room) begin
					next_state = ST_SIZE;
				end
			end
			ST_SIZE: begin
				next_state = ST_SRC;
			end
			ST_SRC: begin
				next_state = ST_DEST;
			end
			ST_DEST: begin
				next_state = ST_WEIGHT;
			end
			ST_WEIGHT: begin
				// last chunk goes straight back to idle
				if (remaining == '0) begin
					next_state = ST_IDLE;
				end else begin
					next_state = ST_WAIT;
				end
			end
			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

	// job progress
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			next_off  <= '0;
			remaining <= '0;
		end else begin
			if (state == ST_IDLE && vertex_valid) begin
				next_off  <= mem_pkg::addr_t'(vertex_edge_idx) * `EF_EDGE_BYTES;
				remaining <= vertex_degree;
			end else if (state == ST_SIZE) begin
				// every later chunk starts line aligned
				next_off  <= calc_aligned + `EF_CACHELINE_BYTES;
				remaining <= remaining - calc_count;
			end
		end
	end

	// chunk payload, held through the command triple
	always_ff @(posedge clock) begin
		if (state == ST_SIZE) begin
			aligned      <= calc_aligned;
			chunk_offset <= calc_start;
			chunk_count  <= calc_count;
		end
	end

////////////////////
// command outputs
////////////////////

	assign vertex_ready  = (state == ST_IDLE);
	assign chunk_start   = (state == ST_SRC);
	assign mem_cmd_valid = (state == ST_SRC) || (state == ST_DEST) || (state == ST_WEIGHT);

	always_comb begin
		case (state)
			ST_DEST: begin
				mem_cmd_addr  = dest_base + aligned;
				mem_cmd_array = mem_pkg::ARRAY_DEST;
			end
			ST_WEIGHT: begin
				mem_cmd_addr  = weight_base + aligned;
				mem_cmd_array = mem_pkg::ARRAY_WEIGHT;
			end
			default: begin
				mem_cmd_addr  = src_base + aligned;
				mem_cmd_array = mem_pkg::ARRAY_SRC;
			end
		endcase
	end

endmodule

/* hdl/edge_unpacker.sv */
////////////////////
// edge unpacker, one chunk at a time
// expects at most one response per array per chunk
// pushes one edge per cycle once all three lines are in
////////////////////

`timescale 1ns/1ps
`include "edge_fetch_settings.svh"

module edge_unpacker (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   vertex_valid,
	input  logic                   chunk_start,
	input  mem_pkg::line_offset_t  chunk_offset,
	input  edge_pkg::edge_count_t  chunk_count,
	input  logic                   mem_resp_valid,
	input  mem_pkg::array_sel_t    mem_resp_array,
	input  mem_pkg::cacheline_t    mem_resp_data,
	output logic                   chunk_busy,
	output logic                   push,
	output edge_pkg::edge_word_t   push_src,
	output edge_pkg::edge_word_t   push_dest,
	output edge_pkg::edge_word_t   push_weight,
	output edge_pkg::edge_count_t  push_seq
);

	localparam int WORD_BITS = `EF_EDGE_BYTES * 8;

	// line registers indexed by array id
	mem_pkg::cacheline_t   lines [3];
	logic [2:0]            loaded;

	// walk through the chunk
	mem_pkg::line_offset_t pos;
	edge_pkg::edge_count_t left;
	edge_pkg::edge_count_t seq;

	always_ff @(posedge clock) begin
		if (mem_resp_valid) begin
			lines[mem_resp_array] <= mem_resp_data;
		end
	end

////////////////////
// chunk control
////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			chunk_busy <= 1'b0;
			loaded     <= '0;
			pos        <= '0;
			left       <= '0;
		end else begin
			if (chunk_start) begin
				chunk_busy <= 1'b1;
				loaded     <= '0;
				pos        <= chunk_offset;
				left       <= chunk_count;
			end else begin
				if (mem_resp_valid) begin
					loaded[mem_resp_array] <= 1'b1;
				end
				if (push) begin
					pos  <= pos + 1'b1;
					left <= left - 1'b1;
					// last edge of the chunk
					if (left == edge_pkg::edge_count_t'(1)) begin
						chunk_busy <= 1'b0;
						loaded     <= '0;
					end
				end
			end
		end
	end

	// per-vertex sequence number
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			seq <= '0;
		end else if (vertex_valid) begin
			seq <= '0;
		end else if (push) begin
			seq <= seq + 1'b1;
		end
	end

////////////////////
// edge extraction
////////////////////

	assign push        = chunk_busy && (&loaded);
	assign push_src    = lines[mem_pkg::ARRAY_SRC][pos*WORD_BITS +: WORD_BITS];
	assign push_dest   = lines[mem_pkg::ARRAY_DEST][pos*WORD_BITS +: WORD_BITS];
	assign push_weight = lines[mem_pkg::ARRAY_WEIGHT][pos*WORD_BITS +: WORD_BITS];
	assign push_seq    = seq;

endmodule

/* hdl/edge_queue.sv */
////////////////////
// first-word-fall-through edge FIFO
// a push into a full queue is ignored, the sequencer keeps it from happening
////////////////////

`timescale 1ns/1ps
`include "edge_fetch_settings.svh"

module edge_queue (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   push,
	input  edge_pkg::edge_word_t   push_src,
	input  edge_pkg::edge_word_t   push_dest,
	input  edge_pkg::edge_word_t   push_weight,
	input  edge_pkg::edge_count_t  push_seq,
	input  logic                   edge_pop,
	output logic                   edge_valid,
	output edge_pkg::edge_word_t   edge_src,
	output edge_pkg::edge_word_t   edge_dest,
	output edge_pkg::edge_word_t   edge_weight,
	output edge_pkg::edge_count_t  edge_seq,
	output logic                   queue_room
);

	localparam int DEPTH    = `EF_QUEUE_DEPTH;
	localparam int PTR_BITS = $clog2(DEPTH);

	edge_pkg::edge_word_t  src_mem    [DEPTH];
	edge_pkg::edge_word_t  dest_mem   [DEPTH];
	edge_pkg::edge_word_t  weight_mem [DEPTH];
	edge_pkg::edge_count_t seq_mem    [DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   count;
	logic                do_push;
	logic                do_pop;

	assign do_push = push && (count != (PTR_BITS+1)'(DEPTH));
	assign do_pop  = edge_pop && edge_valid;

	always_ff @(posedge clock) begin
		if (do_push) begin
			src_mem[wr_ptr]    <= push_src;
			dest_mem[wr_ptr]   <= push_dest;
			weight_mem[wr_ptr] <= push_weight;
			seq_mem[wr_ptr]    <= push_seq;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// push and pop together leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// head read straight from storage
	assign edge_valid  = (count != '0);
	assign edge_src    = src_mem[rd_ptr];
	assign edge_dest   = dest_mem[rd_ptr];
	assign edge_weight = weight_mem[rd_ptr];
	assign edge_seq    = seq_mem[rd_ptr];

	// room for a whole line of edges
	assign queue_room = (count <= (PTR_BITS+1)'(DEPTH - `EF_EDGES_PER_LINE));

endmodule

/* hdl/edge_fetch_top.sv */
////////////////////
// edge fetch unit top
// one vertex job in flight, accepted only while vertex_ready is high
// vertex_id is carried at the job interface for the compute unit
////////////////////

`timescale 1ns/1ps

module edge_fetch_top (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   vertex_valid,
	input  edge_pkg::vertex_id_t   vertex_id,
	input  edge_pkg::edge_count_t  vertex_edge_idx,
	input  edge_pkg::edge_count_t  vertex_degree,
	input  mem_pkg::addr_t         src_base,
	input  mem_pkg::addr_t         dest_base,
	input  mem_pkg::addr_t         weight_base,
	input  logic                   mem_resp_valid,
	input  mem_pkg::array_sel_t    mem_resp_array,
	input  mem_pkg::cacheline_t    mem_resp_data,
	input  logic                   edge_pop,
	output logic                   vertex_ready,
	output logic                   mem_cmd_valid,
	output mem_pkg::addr_t         mem_cmd_addr,
	output mem_pkg::array_sel_t    mem_cmd_array,
	output logic                   edge_valid,
	output edge_pkg::edge_word_t   edge_src,
	output edge_pkg::edge_word_t   edge_dest,
	output edge_pkg::edge_word_t   edge_weight,
	output edge_pkg::edge_count_t  edge_seq
);

	// sequencer to unpacker
	logic                  chunk_start;
	mem_pkg::line_offset_t chunk_offset;
	edge_pkg::edge_count_t chunk_count;
	logic                  chunk_busy;

	// unpacker to queue
	logic                  push;
	edge_pkg::edge_word_t  push_src;
	edge_pkg::edge_word_t  push_dest;
	edge_pkg::edge_word_t  push_weight;
	edge_pkg::edge_count_t push_seq;
	logic                  queue_room;

	edge_cmd_seq cmd_seq_i (
		.clock           (clock),
		.rstn            (rstn),
		.vertex_valid    (vertex_valid),
		.vertex_edge_idx (vertex_edge_idx),
		.vertex_degree   (vertex_degree),
		.src_base        (src_base),
		.dest_base       (dest_base),
		.weight_base     (weight_base),
		.chunk_busy      (chunk_busy),
		.queue_room      (queue_room),
		.vertex_ready    (vertex_ready),
		.mem_cmd_valid   (mem_cmd_valid),
		.mem_cmd_addr    (mem_cmd_addr),
		.mem_cmd_array   (mem_cmd_array),
		.chunk_start     (chunk_start),
		.chunk_offset    (chunk_offset),
		.chunk_count     (chunk_count)
	);

	edge_unpacker unpacker_i (
		.clock          (clock),
		.rstn           (rstn),
		.vertex_valid   (vertex_valid),
		.chunk_start    (chunk_start),
		.chunk_offset   (chunk_offset),
		.chunk_count    (chunk_count),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp_array (mem_resp_array),
		.mem_resp_data  (mem_resp_data),
		.chunk_busy     (chunk_busy),
		.push           (push),
		.push_src       (push_src),
		.push_dest      (push_dest),
		.push_weight    (push_weight),
		.push_seq       (push_seq)
	);

	edge_queue queue_i (
		.clock       (clock),
		.rstn        (rstn),
		.push        (push),
		.push_src    (push_src),
		.push_dest   (push_dest),
		.push_weight (push_weight),
		.push_seq    (push_seq),
		.edge_pop    (edge_pop),
		.edge_valid  (edge_valid),
		.edge_src    (edge_src),
		.edge_dest   (edge_dest),
		.edge_weight (edge_weight),
		.edge_seq    (edge_seq),
		.queue_room  (queue_room)
	);

endmodule

/* bench/edge_fetch_tb.sv */
////////////////////
// testbench for the edge fetch unit
// memory model answers each line read after 1 to 8 cycles in any order
// jobs run one after another and each drains before the next starts
////////////////////

`timescale 1ns/1ps
`include "edge_fetch_settings.svh"

module edge_fetch_tb;

	localparam int MEM_WORDS    = 256;
	localparam int NUM_JOBS     = 6;
	localparam int STALL_CYCLES = 150;
	localparam int WAIT_LIMIT   = 3000;
	localparam int WORD_BITS    = `EF_EDGE_BYTES * 8;
	localparam mem_pkg::addr_t SRC_BASE    = 32'h0001_0000;
	localparam mem_pkg::addr_t DEST_BASE   = 32'h0002_0000;
	localparam mem_pkg::addr_t WEIGHT_BASE = 32'h0003_0000;

	// job table with id, first edge index, degree and pop stall
	edge_pkg::vertex_id_t  job_id    [NUM_JOBS] = '{32'd100, 32'd101, 32'd102,
		32'd103, 32'd104, 32'd105};
	edge_pkg::edge_count_t job_idx   [NUM_JOBS] = '{16'd0, 16'd13, 16'd37, 16'd50,
		16'd20, 16'd130};
	edge_pkg::edge_count_t job_deg   [NUM_JOBS] = '{16'd16, 16'd40, 16'd7, 16'd80,
		16'd0, 16'd25};
	bit                    job_stall [NUM_JOBS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

	logic                  clock;
	logic                  rstn;
	logic                  vertex_valid;
	edge_pkg::vertex_id_t  vertex_id;
	edge_pkg::edge_count_t vertex_edge_idx;
	edge_pkg::edge_count_t vertex_degree;
	logic                  mem_resp_valid;
	mem_pkg::array_sel_t   mem_resp_array;
	mem_pkg::cacheline_t   mem_resp_data;
	logic                  edge_pop;
	logic                  vertex_ready;
	logic                  mem_cmd_valid;
	mem_pkg::addr_t        mem_cmd_addr;
	mem_pkg::array_sel_t   mem_cmd_array;
	logic                  edge_valid;
	edge_pkg::edge_word_t  edge_src;
	edge_pkg::edge_word_t  edge_dest;
	edge_pkg::edge_word_t  edge_weight;
	edge_pkg::edge_count_t edge_seq;

	// memory contents
	edge_pkg::edge_word_t  src_words    [MEM_WORDS];
	edge_pkg::edge_word_t  dest_words   [MEM_WORDS];
	edge_pkg::edge_word_t  weight_words [MEM_WORDS];

	// expected commands, chunk sizes and edges
	mem_pkg::addr_t        exp_cmd_addr  [$];
	mem_pkg::array_sel_t   exp_cmd_array [$];
	edge_pkg::edge_count_t exp_chunk_cnt [$];
	edge_pkg::edge_word_t  exp_src       [$];
	edge_pkg::edge_word_t  exp_dest      [$];
	edge_pkg::edge_word_t  exp_weight    [$];
	edge_pkg::edge_count_t exp_seq       [$];

	// reads waiting for their response
	mem_pkg::addr_t        pend_addr  [$];
	mem_pkg::array_sel_t   pend_array [$];
	int                    pend_due   [$];

	logic [31:0] rand_state;
	int          cycle;
	int          errors;
	int          checks;
	int          tests;
	int          issued_edges;
	int          popped_edges;
	bit          stall;

	edge_fetch_top dut_i (
		.clock           (clock),
		.rstn            (rstn),
		.vertex_valid    (vertex_valid),
		.vertex_id       (vertex_id),
		.vertex_edge_idx (vertex_edge_idx),
		.vertex_degree   (vertex_degree),
		.src_base        (SRC_BASE),
		.dest_base       (DEST_BASE),
		.weight_base     (WEIGHT_BASE),
		.mem_resp_valid  (mem_resp_valid),
		.mem_resp_array  (mem_resp_array),
		.mem_resp_data   (mem_resp_data),
		.edge_pop        (edge_pop),
		.vertex_ready    (vertex_ready),
		.mem_cmd_valid   (mem_cmd_valid),
		.mem_cmd_addr    (mem_cmd_addr),
		.mem_cmd_array   (mem_cmd_array),
		.edge_valid      (edge_valid),
		.edge_src        (edge_src),
		.edge_dest       (edge_dest),
		.edge_weight     (edge_weight),
		.edge_seq        (edge_seq)
	);

	always #10 clock = ~clock;

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

////////////////////
// compare tasks
////////////////////

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("Error %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input edge_pkg::edge_word_t got,
		input edge_pkg::edge_word_t exp);
		checks++;
		if (got !== exp) begin
			$display("Error %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input edge_pkg::edge_count_t got,
		input edge_pkg::edge_count_t exp);
		checks++;
		if (got !== exp) begin
			$display("Error %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input mem_pkg::addr_t got,
		input mem_pkg::addr_t exp);
		checks++;
		if (got !== exp) begin
			$display("Error %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_array(input string name, input mem_pkg::array_sel_t got,
		input mem_pkg::array_sel_t exp);
		checks++;
		if (got !== exp) begin
			$display("Error %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

////////////////////
// reference model
////////////////////

	function automatic mem_pkg::addr_t array_base(input mem_pkg::array_sel_t sel);
		case (sel)
			mem_pkg::ARRAY_DEST:   return DEST_BASE;
			mem_pkg::ARRAY_WEIGHT: return WEIGHT_BASE;
			default:               return SRC_BASE;
		endcase
	endfunction

	function automatic edge_pkg::edge_word_t array_word(input mem_pkg::array_sel_t sel,
		input int idx);
		case (sel)
			mem_pkg::ARRAY_DEST:   return dest_words[idx];
			mem_pkg::ARRAY_WEIGHT: return weight_words[idx];
			default:               return src_words[idx];
		endcase
	endfunction

	// chunks end at a line boundary or at the end of the vertex
	task automatic build_expect(input edge_pkg::edge_count_t idx,
		input edge_pkg::edge_count_t deg);
		int             pos;
		int             left;
		int             cnt;
		int             k;
		int             e;
		mem_pkg::addr_t line_addr;
		pos = int'(idx);
		left = int'(deg);
		k = 0;
		while (left > 0) begin
			line_addr = mem_pkg::addr_t'((pos / `EF_EDGES_PER_LINE) * `EF_CACHELINE_BYTES);
			cnt = `EF_EDGES_PER_LINE - (pos % `EF_EDGES_PER_LINE);
			if (left < cnt) begin
				cnt = left;
			end
			exp_cmd_addr.push_back(SRC_BASE + line_addr);
			exp_cmd_array.push_back(mem_pkg::ARRAY_SRC);
			exp_cmd_addr.push_back(DEST_BASE + line_addr);
			exp_cmd_array.push_back(mem_pkg::ARRAY_DEST);
			exp_cmd_addr.push_back(WEIGHT_BASE + line_addr);
			exp_cmd_array.push_back(mem_pkg::ARRAY_WEIGHT);
			exp_chunk_cnt.push_back(edge_pkg::edge_count_t'(cnt));
			for (e = 0; e < cnt; e++) begin
				exp_src.push_back(src_words[pos + e]);
				exp_dest.push_back(dest_words[pos + e]);
				exp_weight.push_back(weight_words[pos + e]);
				exp_seq.push_back(edge_pkg::edge_count_t'(k));
				k++;
			end
			pos += cnt;
			left -= cnt;
		end
	endtask

////////////////////
// per-cycle models
////////////////////

	// answer the earliest due read with at most one response per cycle
	task automatic serve_memory();
		int                  best;
		int                  i;
		int                  w;
		int                  word_base;
		mem_pkg::addr_t      off;
		mem_pkg::cacheline_t line;
		mem_resp_valid = 1'b0;
		best = -1;
		for (i = 0; i < pend_due.size(); i++) begin
			if (pend_due[i] <= cycle && (best < 0 || pend_due[i] < pend_due[best])) begin
				best = i;
			end
		end
		if (best >= 0) begin
			off = pend_addr[best] - array_base(pend_array[best]);
			line = '0;
			if (off > mem_pkg::addr_t'((MEM_WORDS - `EF_EDGES_PER_LINE) * `EF_EDGE_BYTES)) begin
				$display("memory read at 0x%0h falls outside the modelled arrays",
					pend_addr[best]);
				errors++;
			end else begin
				word_base = int'(off) / `EF_EDGE_BYTES;
				for (w = 0; w < `EF_EDGES_PER_LINE; w++) begin
					line[w*WORD_BITS +: WORD_BITS] = array_word(pend_array[best], word_base + w);
				end
			end
			mem_resp_valid = 1'b1;
			mem_resp_array = pend_array[best];
			mem_resp_data = line;
			pend_addr.delete(best);
			pend_array.delete(best);
			pend_due.delete(best);
		end
	endtask

	task automatic watch_commands();
		if (mem_cmd_valid) begin
			if (exp_cmd_addr.size() == 0) begin
				$display("unexpected memory read at 0x%0h", mem_cmd_addr);
				errors++;
			end else begin
				check_addr("mem_cmd_addr", mem_cmd_addr, exp_cmd_addr.pop_front());
				check_array("mem_cmd_array", mem_cmd_array, exp_cmd_array.pop_front());
			end
			// previous chunk is fully pushed once a new src read goes out
			if (mem_cmd_array == mem_pkg::ARRAY_SRC) begin
				if (issued_edges - popped_edges > `EF_QUEUE_DEPTH - `EF_EDGES_PER_LINE) begin
					$display("chunk started with fewer than a line of free queue entries");
					errors++;
				end
				if (exp_chunk_cnt.size() > 0) begin
					issued_edges += int'(exp_chunk_cnt.pop_front());
				end
			end
			pend_addr.push_back(mem_cmd_addr);
			pend_array.push_back(mem_cmd_array);
			pend_due.push_back(cycle + 1 + int'((next_rand() >> 16) % 8));
		end
	endtask

	task automatic handle_pops();
		edge_pop = 1'b0;
		if (edge_valid && !stall) begin
			if (exp_src.size() == 0) begin
				$display("edge appeared with none expected, seq 0x%0h", edge_seq);
				errors++;
			end else begin
				check_word("edge_src", edge_src, exp_src.pop_front());
				check_word("edge_dest", edge_dest, exp_dest.pop_front());
				check_word("edge_weight", edge_weight, exp_weight.pop_front());
				check_count("edge_seq", edge_seq, exp_seq.pop_front());
			end
			edge_pop = 1'b1;
			popped_edges++;
		end
	endtask

	// inputs change only here on the falling edge
	task automatic tick();
		@(negedge clock);
		cycle++;
		serve_memory();
		watch_commands();
		handle_pops();
	endtask

////////////////////
// job runner
////////////////////

	task automatic run_job(input int j, output bit ok);
		int start_err;
		int n;
		start_err = errors;
		ok = 1'b1;
		tests++;
		n = 0;
		while (!vertex_ready && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (!vertex_ready) begin
			$display("timeout waiting for vertex_ready before job %0d", j);
			errors++;
			ok = 1'b0;
			return;
		end
		build_expect(job_idx[j], job_deg[j]);
		vertex_valid = 1'b1;
		vertex_id = job_id[j];
		vertex_edge_idx = job_idx[j];
		vertex_degree = job_deg[j];
		tick();
		vertex_valid = 1'b0;
		check_bit("vertex_ready", vertex_ready, 1'b0);
		if (job_stall[j]) begin
			stall = 1'b1;
			repeat (STALL_CYCLES) tick();
			stall = 1'b0;
		end
		n = 0;
		while (!(vertex_ready && exp_src.size() == 0 && exp_cmd_addr.size() == 0)
			&& n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (!(vertex_ready && exp_src.size() == 0 && exp_cmd_addr.size() == 0)) begin
			$display("timeout in job %0d, %0d edges and %0d reads still missing",
				j, exp_src.size(), exp_cmd_addr.size());
			errors++;
			ok = 1'b0;
		end
		// idle cycles to catch stray reads or edges
		repeat (4) tick();
		$display("test %0d vertex %0d index %0d degree %0d stall %0d: %0d errors",
			tests, job_id[j], job_idx[j], job_deg[j], job_stall[j], errors - start_err);
	endtask

	initial begin
		bit ok;
		int j;
		int i;
		clock = 1'b0;
		rstn = 1'b0;
		vertex_valid = 1'b0;
		vertex_id = '0;
		vertex_edge_idx = '0;
		vertex_degree = '0;
		mem_resp_valid = 1'b0;
		mem_resp_array = mem_pkg::ARRAY_SRC;
		mem_resp_data = '0;
		edge_pop = 1'b0;
		stall = 1'b0;
		cycle = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		issued_edges = 0;
		popped_edges = 0;
		rand_state = 32'd28;
		for (i = 0; i < MEM_WORDS; i++) begin
			src_words[i] = next_rand();
			dest_words[i] = next_rand();
			weight_words[i] = next_rand();
		end

		repeat (8) tick();
		rstn = 1'b1;
		tick();

		// reset values
		tests++;
		check_bit("vertex_ready", vertex_ready, 1'b1);
		check_bit("mem_cmd_valid", mem_cmd_valid, 1'b0);
		check_bit("edge_valid", edge_valid, 1'b0);
		$display("test %0d reset values: %0d errors", tests, errors);

		ok = 1'b1;
		for (j = 0; j < NUM_JOBS && ok; j++) begin
			run_job(j, ok);
		end

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* edge_fetch.f */
+incdir+include
hdl/mem_pkg.sv
hdl/edge_pkg.sv
hdl/edge_cmd_seq.sv
hdl/edge_unpacker.sv
hdl/edge_queue.sv
hdl/edge_fetch_top.sv
bench/edge_fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the edge fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f edge_fetch.f \
	--top-module edge_fetch_tb -o edge_fetch_sim \
	&& sim_out="$(./obj_dir/edge_fetch_sim)" \
	&& echo "$sim_out" \
	&& grep -q "^TEST PASS$" <<< "$sim_out" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
